//--- hw/sdspi_settings.svh
`ifndef SDSPI_SETTINGS_SVH
`define SDSPI_SETTINGS_SVH

// Register bus widths
`define SDSPI_DATA_BITS 32
`define SDSPI_ADDR_BITS 4

// Byte FIFO depth as log2, 16 entries
`define SDSPI_FIFO_LOG2 4

// Transfer byte counter width
`define SDSPI_CNT_BITS 16

// Register word indexes
`define SDSPI_REG_SCKDIV 4'd0
`define SDSPI_REG_CTRL   4'd1
`define SDSPI_REG_TXDATA 4'd2
`define SDSPI_REG_RXDATA 4'd3

`endif

//--- hw/sdspi_pkg.sv
`include "sdspi_settings.svh"

package sdspi_pkg;

    // Host register request
    typedef struct packed {
        logic [`SDSPI_ADDR_BITS-1:0] addr;      // Word index
        logic                        write;
        logic [`SDSPI_DATA_BITS-1:0] wdata;
    } reg_req_t;

    // Host register response
    typedef struct packed {
        logic [`SDSPI_DATA_BITS-1:0] rdata;
    } reg_resp_t;

    // Transfer command from the CTRL register
    typedef struct packed {
        logic                       generate_crc;  // Append CRC7 byte after data
        logic                       rx_ena;        // Receive instead of transmit
        logic [`SDSPI_CNT_BITS-1:0] byte_cnt;
    } xfer_cmd_t;

    // SPI engine states, readable through CTRL[6:4]
    typedef enum logic [2:0] {
        st_idle      = 3'h0,
        st_wait_edge = 3'h1,
        st_send      = 3'h2,
        st_recv      = 3'h3,
        st_ending    = 3'h5
    } spi_state_e;

endpackage

//--- hw/byte_fifo.sv
`timescale 1ns/10ps

module byte_fifo #(
    parameter int log2_depth = 4
) (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic [7:0] i_data,      // Push side
    input  logic       i_valid,
    output logic       o_ready,     // Low when full
    output logic [7:0] o_data,      // Head byte
    output logic       o_valid,     // High when not empty
    input  logic       i_ready      // Pop request
);

localparam logic [log2_depth:0] depth = {1'b1, {log2_depth{1'b0}}};

logic [7:0]            mem [0:(1 << log2_depth)-1];
logic [log2_depth-1:0] wr_ptr;
logic [log2_depth-1:0] rd_ptr;
logic [log2_depth:0]   count;
logic                  w_push;
logic                  w_pop;

assign o_ready = (count != depth);
assign o_valid = (count != '0);
assign o_data  = mem[rd_ptr];           // Visible the cycle after a push

assign w_push = i_valid & o_ready;
assign w_pop  = i_ready & o_valid;

always_ff @(posedge i_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (w_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (w_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        case ({w_push, w_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;    // Both or neither
        endcase
    end
end

always_ff @(posedge i_clk) begin
    if (w_push) begin
        mem[wr_ptr] <= i_data;
    end
end

// Pointers may meet on a push only while the buffer is empty
a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_nrst)
    w_push |-> (wr_ptr != rd_ptr) || (count == '0));

// Pointers may meet on a pop only while the buffer is full
a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_nrst)
    w_pop |-> (wr_ptr != rd_ptr) || (count == depth));

endmodule

//--- hw/sdspi_regs.sv
`timescale 1ns/10ps

`include "sdspi_settings.svh"

module sdspi_regs import sdspi_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  reg_req_t    i_req,
    input  logic        i_req_valid,
    output logic        o_req_ready,
    output reg_resp_t   o_resp,
    output logic        o_resp_valid,
    input  logic        i_resp_ready,
    output xfer_cmd_t   o_cmd,          // Command slot
    output logic        o_cmd_valid,
    input  logic        i_cmd_ready,
    output logic [15:0] o_sckdiv,       // Half-period divider
    input  spi_state_e  i_state,
    output logic [7:0]  o_tx_data,      // Tx FIFO push
    output logic        o_tx_valid,
    input  logic        i_tx_ready,
    input  logic [7:0]  i_rx_data,      // Rx FIFO pop
    input  logic        i_rx_valid,
    output logic        o_rx_ready
);

logic                        w_accept;
logic                        w_wr;
logic                        w_rd;
logic                        w_busy;
logic [`SDSPI_DATA_BITS-1:0] w_rdata;
logic [15:0]                 sckdiv;
xfer_cmd_t                   cmd;
logic                        cmd_valid;
reg_resp_t                   resp;
logic                        resp_valid;

// New request only once the previous response leaves
assign o_req_ready = ~resp_valid | i_resp_ready;
assign w_accept    = i_req_valid & o_req_ready;
assign w_wr        = w_accept & i_req.write;
assign w_rd        = w_accept & ~i_req.write;

assign w_busy = cmd_valid | (i_state != st_idle);

assign o_tx_data  = i_req.wdata[7:0];
assign o_tx_valid = w_wr & (i_req.addr == `SDSPI_REG_TXDATA);   // Dropped when full
assign o_rx_ready = w_rd & (i_req.addr == `SDSPI_REG_RXDATA);

always_comb begin
    w_rdata = '0;
    case (i_req.addr)
        `SDSPI_REG_SCKDIV: begin
            w_rdata[15:0] = sckdiv;
        end
        `SDSPI_REG_CTRL: begin
            w_rdata[3]     = w_busy;
            w_rdata[6:4]   = i_state;
            w_rdata[7]     = cmd.generate_crc;
            w_rdata[8]     = cmd.rx_ena;
            w_rdata[31:16] = cmd.byte_cnt;
        end
        `SDSPI_REG_TXDATA: begin
            w_rdata[31] = ~i_tx_ready;  // Tx FIFO full
        end
        `SDSPI_REG_RXDATA: begin
            w_rdata[7:0] = i_rx_data;
            w_rdata[31]  = ~i_rx_valid; // Rx FIFO empty
        end
        default: begin
            w_rdata = '0;
        end
    endcase
end

always_ff @(posedge i_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        sckdiv    <= '0;
        cmd       <= '0;
        cmd_valid <= 1'b0;
    end else begin
        if (w_wr && (i_req.addr == `SDSPI_REG_SCKDIV)) begin
            sckdiv <= i_req.wdata[15:0];
        end
        if (w_wr && (i_req.addr == `SDSPI_REG_CTRL)) begin
            cmd.generate_crc <= i_req.wdata[7];
            cmd.rx_ena       <= i_req.wdata[8];
            cmd.byte_cnt     <= i_req.wdata[31:16];
            cmd_valid        <= 1'b1;   // Overwrites a pending command
        end else if (i_cmd_ready) begin
            cmd_valid <= 1'b0;
        end
    end
end

always_ff @(posedge i_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        resp_valid <= 1'b0;
    end else if (w_accept) begin
        resp_valid <= 1'b1;
    end else if (i_resp_ready) begin
        resp_valid <= 1'b0;
    end
end

always_ff @(posedge i_clk) begin
    if (w_accept) begin
        resp.rdata <= w_rdata;
    end
end

assign o_resp       = resp;
assign o_resp_valid = resp_valid;
assign o_cmd        = cmd;
assign o_cmd_valid  = cmd_valid;
assign o_sckdiv     = sckdiv;

// Held response keeps both its data and its valid
a_resp_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
    (resp_valid && !i_resp_ready) |=> resp_valid && $stable(resp));

endmodule

//--- hw/sdspi_engine.sv
`timescale 1ns/10ps

`include "sdspi_settings.svh"

module sdspi_engine import sdspi_pkg::*; (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic [15:0] i_sckdiv,
    input  xfer_cmd_t   i_cmd,
    input  logic        i_cmd_valid,
    output logic        o_cmd_ready,    // Only in idle
    input  logic [7:0]  i_tx_data,
    input  logic        i_tx_valid,
    output logic        o_tx_ready,     // Takes a byte from the Tx FIFO
    output logic [7:0]  o_rx_data,
    output logic        o_rx_valid,
    input  logic        i_rx_ready,
    output spi_state_e  o_state,
    output logic        o_sclk,
    output logic        o_cs_n,
    output logic        o_mosi,
    input  logic        i_miso
);

logic [15:0]                div_q;
logic [15:0]                scaler_cnt;
logic                       level;
spi_state_e                 state;
logic                       cs;
logic [7:0]                 shiftreg;
logic [2:0]                 bit_cnt;
logic [`SDSPI_CNT_BITS-1:0] byte_cnt;
logic                       generate_crc;
logic                       rx_ena;
logic                       rx_synced;      // Start bit seen
logic                       rx_push;
logic [6:0]                 crc7;
logic [7:0]                 tx_val;         // Next byte to send
logic [7:0]                 rx_val;
logic                       w_tick;
logic                       w_posedge;
logic                       w_negedge;
logic                       w_crc_inv;
logic [6:0]                 w_crc_next;
logic                       w_cmd_take;
logic                       w_first_take;
logic                       w_next_take;
logic                       w_crc_take;
logic                       w_byte_done;
logic [7:0]                 w_tx_byte;
logic [7:0]                 w_shift_in;

// Divider of zero never ticks, so the engine freezes
assign w_tick    = (|i_sckdiv) && (i_sckdiv == div_q) && (scaler_cnt == i_sckdiv - 1'b1);
assign w_posedge = w_tick & ~level;
assign w_negedge = w_tick & level;

// CRC7 with x^7 + x^3 + 1 over the bit on MOSI
assign w_crc_inv  = crc7[6] ^ shiftreg[7];
assign w_crc_next = {crc7[5:3], crc7[2] ^ w_crc_inv, crc7[1:0], w_crc_inv};

assign w_shift_in = {shiftreg[6:0], i_miso};
assign w_tx_byte  = i_tx_valid ? i_tx_data : 8'hff;   // Empty FIFO sends idle ones

assign o_cmd_ready  = (state == st_idle);
assign w_cmd_take   = i_cmd_valid & o_cmd_ready;
assign w_first_take = w_cmd_take & (|i_cmd.byte_cnt) & ~i_cmd.rx_ena;
assign w_next_take  = (state == st_send) & w_posedge & (bit_cnt == 3'd0) & (|byte_cnt);
assign w_crc_take   = (state == st_send) & w_posedge & (bit_cnt == 3'd0) & ~(|byte_cnt)
                    & generate_crc;
assign w_byte_done  = (state == st_recv) & w_posedge & (bit_cnt == 3'd0);
assign o_tx_ready   = w_first_take | w_next_take;

always_ff @(posedge i_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        div_q      <= '0;
        scaler_cnt <= '0;
        level      <= 1'b1;
    end else if (i_sckdiv != div_q) begin
        div_q      <= i_sckdiv;         // New divider restarts the scaler
        scaler_cnt <= '0;
    end else if (w_tick) begin
        scaler_cnt <= '0;
        level      <= ~level;
    end else if (|i_sckdiv) begin
        scaler_cnt <= scaler_cnt + 1'b1;
    end
end

always_ff @(posedge i_clk or negedge i_nrst) begin
    if (!i_nrst) begin
        state        <= st_idle;
        cs           <= 1'b0;
        shiftreg     <= '1;
        bit_cnt      <= '0;
        byte_cnt     <= '0;
        generate_crc <= 1'b0;
        rx_ena       <= 1'b0;
        rx_synced    <= 1'b0;
        rx_push      <= 1'b0;
        crc7         <= '0;
    end else begin
        rx_push <= 1'b0;
        case (state)
            st_idle: begin
                if (w_cmd_take) begin
                    generate_crc <= i_cmd.generate_crc;
                    rx_ena       <= i_cmd.rx_ena;
                    rx_synced    <= 1'b0;
                    crc7         <= '0;
                    if (|i_cmd.byte_cnt) begin
                        byte_cnt <= i_cmd.byte_cnt - 1'b1;
                        state    <= st_wait_edge;
                    end
                end
            end
            st_wait_edge: begin
                if (w_negedge) begin
                    if (rx_ena && (!i_rx_ready || rx_push)) begin
                        cs <= 1'b0;             // Hold off until the Rx FIFO has room
                    end else begin
                        cs       <= 1'b1;
                        bit_cnt  <= 3'd7;
                        shiftreg <= tx_val;
                        state    <= rx_ena ? st_recv : st_send;
                    end
                end
            end
            st_send: begin
                if (w_negedge) begin
                    shiftreg <= {shiftreg[6:0], 1'b1};
                    if (|bit_cnt) begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                if (w_posedge) begin
                    crc7 <= w_crc_next;
                    if (bit_cnt == 3'd0) begin
                        if (|byte_cnt) begin
                            byte_cnt <= byte_cnt - 1'b1;
                            state    <= st_wait_edge;
                        end else if (generate_crc) begin
                            generate_crc <= 1'b0;   // CRC byte goes out once
                            state        <= st_wait_edge;
                        end else begin
                            state <= st_ending;
                        end
                    end
                end
            end
            st_recv: begin
                if (w_negedge && rx_synced && (|bit_cnt)) begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
                if (w_posedge) begin
                    shiftreg <= w_shift_in;
                    if (!rx_synced) begin
                        rx_synced <= ~i_miso;   // First low bit is the MSB
                    end
                    if (bit_cnt == 3'd0) begin
                        rx_push <= 1'b1;
                        if (|byte_cnt) begin
                            byte_cnt <= byte_cnt - 1'b1;
                            state    <= st_wait_edge;
                        end else begin
                            state <= st_ending;
                        end
                    end
                end
            end
            st_ending: begin
                if (w_negedge) begin
                    cs       <= 1'b0;
                    shiftreg <= '1;
                    state    <= st_idle;
                end
            end
            default: begin
                state <= st_idle;
            end
        endcase
    end
end

always_ff @(posedge i_clk) begin
    if (w_cmd_take) begin
        tx_val <= i_cmd.rx_ena ? 8'hff : w_tx_byte;
    end else if (w_next_take) begin
        tx_val <= w_tx_byte;
    end else if (w_crc_take) begin
        tx_val <= {w_crc_next, 1'b1};           // CRC7 with end bit
    end
    if (w_byte_done) begin
        rx_val <= w_shift_in;
    end
end

assign o_rx_data  = rx_val;
assign o_rx_valid = rx_push;
assign o_state    = state;
assign o_sclk     = level & cs;
assign o_cs_n     = ~cs;
assign o_mosi     = rx_ena | shiftreg[7];      // Receive keeps MOSI high

a_idle_deselected: assert property (@(posedge i_clk) disable iff (!i_nrst)
    (state == st_idle) |-> o_cs_n);

// The wait before each byte guarantees room when the byte lands
a_rx_no_loss: assert property (@(posedge i_clk) disable iff (!i_nrst)
    o_rx_valid |-> i_rx_ready);

endmodule

//--- hw/sdspi_top.sv
`timescale 1ns/10ps

`include "sdspi_settings.svh"

module sdspi_top import sdspi_pkg::*; (
    input  logic      i_clk,
    input  logic      i_nrst,
    input  reg_req_t  i_req,
    input  logic      i_req_valid,
    output logic      o_req_ready,
    output reg_resp_t o_resp,
    output logic      o_resp_valid,
    input  logic      i_resp_ready,
    output logic      o_sclk,
    output logic      o_cs_n,
    output logic      o_mosi,
    input  logic      i_miso
);

xfer_cmd_t   w_cmd;
logic        w_cmd_valid;
logic        w_cmd_ready;
logic [15:0] w_sckdiv;
spi_state_e  w_state;
logic [7:0]  w_txf_wdata;   // Host side of Tx FIFO
logic        w_txf_wvalid;
logic        w_txf_wready;
logic [7:0]  w_txf_rdata;   // Engine side of Tx FIFO
logic        w_txf_rvalid;
logic        w_txf_rready;
logic [7:0]  w_rxf_wdata;   // Engine side of Rx FIFO
logic        w_rxf_wvalid;
logic        w_rxf_wready;
logic [7:0]  w_rxf_rdata;   // Host side of Rx FIFO
logic        w_rxf_rvalid;
logic        w_rxf_rready;

sdspi_regs u_regs (
    .i_clk        (i_clk),
    .i_nrst       (i_nrst),
    .i_req        (i_req),
    .i_req_valid  (i_req_valid),
    .o_req_ready  (o_req_ready),
    .o_resp       (o_resp),
    .o_resp_valid (o_resp_valid),
    .i_resp_ready (i_resp_ready),
    .o_cmd        (w_cmd),
    .o_cmd_valid  (w_cmd_valid),
    .i_cmd_ready  (w_cmd_ready),
    .o_sckdiv     (w_sckdiv),
    .i_state      (w_state),
    .o_tx_data    (w_txf_wdata),
    .o_tx_valid   (w_txf_wvalid),
    .i_tx_ready   (w_txf_wready),
    .i_rx_data    (w_rxf_rdata),
    .i_rx_valid   (w_rxf_rvalid),
    .o_rx_ready   (w_rxf_rready)
);

byte_fifo #(
    .log2_depth (`SDSPI_FIFO_LOG2)
) tx_fifo (
    .i_clk   (i_clk),
    .i_nrst  (i_nrst),
    .i_data  (w_txf_wdata),
    .i_valid (w_txf_wvalid),
    .o_ready (w_txf_wready),
    .o_data  (w_txf_rdata),
    .o_valid (w_txf_rvalid),
    .i_ready (w_txf_rready)
);

byte_fifo #(
    .log2_depth (`SDSPI_FIFO_LOG2)
) rx_fifo (
    .i_clk   (i_clk),
    .i_nrst  (i_nrst),
    .i_data  (w_rxf_wdata),
    .i_valid (w_rxf_wvalid),
    .o_ready (w_rxf_wready),
    .o_data  (w_rxf_rdata),
    .o_valid (w_rxf_rvalid),
    .i_ready (w_rxf_rready)
);

sdspi_engine u_engine (
    .i_clk       (i_clk),
    .i_nrst      (i_nrst),
    .i_sckdiv    (w_sckdiv),
    .i_cmd       (w_cmd),
    .i_cmd_valid (w_cmd_valid),
    .o_cmd_ready (w_cmd_ready),
    .i_tx_data   (w_txf_rdata),
    .i_tx_valid  (w_txf_rvalid),
    .o_tx_ready  (w_txf_rready),
    .o_rx_data   (w_rxf_wdata),
    .o_rx_valid  (w_rxf_wvalid),
    .i_rx_ready  (w_rxf_wready),
    .o_state     (w_state),
    .o_sclk      (o_sclk),
    .o_cs_n      (o_cs_n),
    .o_mosi      (o_mosi),
    .i_miso      (i_miso)
);

endmodule

//--- test/tb_sdspi_tasks.svh
task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first error");
endtask

task automatic fail_with(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    abort_run();
endtask

task automatic check_resp(input string name, input reg_resp_t actual, input reg_resp_t expected);
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t: %s = %h, expected %h",
                 $time, name, actual.rdata, expected.rdata);
        abort_run();
    end
endtask

task automatic check_byte(input string name, input logic [7:0] actual, input logic [7:0] expected);
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
        abort_run();
    end
endtask

task automatic check_state(input string name, input spi_state_e actual,
                           input spi_state_e expected);
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t: %s = %s (%0d), expected %s", $time, name,
                 actual.name(), actual, expected.name());
        abort_run();
    end
endtask

task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, actual, expected);
        abort_run();
    end
endtask

task automatic check_count(input string name, input int actual, input int expected);
    if (actual != expected) begin
        $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
        abort_run();
    end
endtask

// Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic random_byte(output logic [7:0] b);
    logic [7:0] acc;
    acc = '0;
    for (int i = 0; i < 8; i++) begin
        acc        = {acc[6:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    b = acc;
endtask

// SD CRC7 over bytes MSB first, returned with the end bit
function automatic logic [7:0] crc7_ref(input logic [7:0] bytes[$]);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    foreach (bytes[i]) begin
        for (int b = 7; b >= 0; b--) begin
            fb  = crc[6] ^ bytes[i][b];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
    end
    return {crc, 1'b1};
endfunction

// Holds valid until the request is taken, returns on the accepting edge
task automatic bus_issue(input logic [`SDSPI_ADDR_BITS-1:0] addr, input logic write,
                         input logic [31:0] data);
    reg_req_t req;
    int       waits;
    req.addr  = addr;
    req.write = write;
    req.wdata = data;
    waits     = 0;
    @(posedge i_clk);
    i_req       <= req;
    i_req_valid <= 1'b1;
    @(negedge i_clk);
    while (!o_req_ready) begin
        waits++;
        if (waits > bus_wait_limit) begin
            fail_with("register request was never accepted");
        end
        @(negedge i_clk);
    end
    @(posedge i_clk);
    i_req_valid <= 1'b0;
endtask

task automatic reg_access(input logic [`SDSPI_ADDR_BITS-1:0] addr, input logic write,
                          input logic [31:0] data, output reg_resp_t resp);
    bus_issue(addr, write, data);
    @(negedge i_clk);
    if (!o_resp_valid) begin
        fail_with("no response on the cycle after an accepted request");
    end
    resp = o_resp;
endtask

task automatic reg_write(input logic [`SDSPI_ADDR_BITS-1:0] addr, input logic [31:0] data);
    reg_resp_t unused;
    reg_access(addr, 1'b1, data, unused);
endtask

task automatic reg_read(input logic [`SDSPI_ADDR_BITS-1:0] addr, output reg_resp_t resp);
    reg_access(addr, 1'b0, 32'h0, resp);
endtask

task automatic start_xfer(input logic [15:0] cnt, input logic crc, input logic rx);
    reg_write(`SDSPI_REG_CTRL, {cnt, 7'h0, rx, crc, 7'h0});
endtask

task automatic push_tx(input logic [7:0] b);
    reg_write(`SDSPI_REG_TXDATA, {24'h0, b});
endtask

// Polls CTRL until busy falls
task automatic wait_idle();
    reg_resp_t r;
    int        polls;
    polls = 0;
    reg_read(`SDSPI_REG_CTRL, r);
    while (r.rdata[3]) begin
        polls++;
        if (polls > max_bytes * 16 * sck_div) begin
            fail_with("CTRL busy never fell after a transfer");
        end
        reg_read(`SDSPI_REG_CTRL, r);
    end
endtask

task automatic card_reset();
    card_bytes.delete();
    miso_bits.delete();
    mosi_count    = 0;
    sclk_falls    = 0;
    mosi_low_seen = 1'b0;
endtask

// Idle ones first, then expect_q MSB first
task automatic load_miso(input int idle_ones);
    repeat (idle_ones) miso_bits.push_back(1'b1);
    foreach (expect_q[i]) begin
        for (int b = 7; b >= 0; b--) begin
            miso_bits.push_back(expect_q[i][b]);
        end
    end
endtask

task automatic check_card_bytes();
    check_count("card byte count", card_bytes.size(), expect_q.size());
    foreach (expect_q[i]) begin
        check_byte($sformatf("card byte %0d", i), card_bytes[i], expect_q[i]);
    end
endtask

task automatic read_rx_bytes(input int first, input int last);
    reg_resp_t r;
    for (int i = first; i < last; i++) begin
        reg_read(`SDSPI_REG_RXDATA, r);
        check_resp($sformatf("RXDATA byte %0d", i), r, {24'h0, expect_q[i]});
    end
endtask

task automatic reset_and_register_access();
    reg_resp_t r;
    reg_resp_t held;
    reg_req_t  blocked;
    @(negedge i_clk);
    check_flag("o_cs_n after reset", o_cs_n, 1'b1);
    check_flag("o_sclk after reset", o_sclk, 1'b0);
    check_flag("o_mosi after reset", o_mosi, 1'b1);
    check_flag("o_req_ready after reset", o_req_ready, 1'b1);
    check_flag("o_resp_valid after reset", o_resp_valid, 1'b0);
    reg_read(`SDSPI_REG_CTRL, r);
    check_resp("CTRL after reset", r, 32'h0);
    check_state("CTRL state after reset", spi_state_e'(r.rdata[6:4]), st_idle);
    check_flag("CTRL busy after reset", r.rdata[3], 1'b0);
    reg_write(`SDSPI_REG_SCKDIV, 32'h0000_a5c3);
    reg_read(`SDSPI_REG_SCKDIV, r);
    check_resp("SCKDIV readback", r, 32'h0000_a5c3);
    @(posedge i_clk);
    i_resp_ready <= 1'b0;               // Host stalls the response
    bus_issue(`SDSPI_REG_SCKDIV, 1'b0, 32'h0);
    @(negedge i_clk);
    check_flag("o_resp_valid held", o_resp_valid, 1'b1);
    held = o_resp;
    check_resp("held SCKDIV", held, 32'h0000_a5c3);
    blocked.addr  = `SDSPI_REG_CTRL;
    blocked.write = 1'b0;
    blocked.wdata = 32'h0;
    @(posedge i_clk);
    i_req       <= blocked;             // Second request waits behind the held response
    i_req_valid <= 1'b1;
    repeat (4) begin
        @(negedge i_clk);
        check_resp("o_resp while held", o_resp, held);
        check_flag("o_req_ready while held", o_req_ready, 1'b0);
        check_flag("o_resp_valid while held", o_resp_valid, 1'b1);
    end
    @(posedge i_clk);
    i_req_valid  <= 1'b0;
    i_resp_ready <= 1'b1;
    @(posedge i_clk);
    @(negedge i_clk);
    check_flag("o_resp_valid after release", o_resp_valid, 1'b0);
    reg_write(`SDSPI_REG_SCKDIV, 32'(sck_div));
    reg_read(`SDSPI_REG_SCKDIV, r);
    check_resp("SCKDIV working value", r, 32'(sck_div));
endtask

task automatic transmit_fifo_bytes();
    logic [7:0] b;
    card_reset();
    expect_q.delete();
    for (int i = 0; i < 8; i++) begin
        random_byte(b);
        expect_q.push_back(b);
        push_tx(b);
    end
    start_xfer(16'd8, 1'b0, 1'b0);
    wait_idle();
    check_card_bytes();
endtask

task automatic transmit_cmd0_with_crc();
    logic [7:0] crc;
    card_reset();
    expect_q = '{8'h40, 8'h00, 8'h00, 8'h00, 8'h00};   // CMD0 frame without CRC
    crc = crc7_ref(expect_q);
    check_byte("reference CRC7 of CMD0", crc, 8'h95);
    foreach (expect_q[i]) begin
        push_tx(expect_q[i]);
    end
    start_xfer(16'd5, 1'b1, 1'b0);
    wait_idle();
    expect_q.push_back(crc);
    check_card_bytes();
endtask

task automatic transmit_underrun_and_full();
    reg_resp_t  r;
    logic [7:0] b;
    card_reset();
    expect_q = '{8'hff, 8'hff, 8'hff};
    start_xfer(16'd3, 1'b0, 1'b0);
    wait_idle();
    check_card_bytes();
    for (int i = 0; i < fifo_depth - 1; i++) begin
        random_byte(b);
        push_tx(b);
    end
    reg_read(`SDSPI_REG_TXDATA, r);
    check_resp("TXDATA one below full", r, 32'h0);
    random_byte(b);
    push_tx(b);
    reg_read(`SDSPI_REG_TXDATA, r);
    check_resp("TXDATA when full", r, 32'h8000_0000);
endtask

task automatic receive_short_response();
    reg_resp_t  r;
    logic [7:0] b;
    card_reset();
    expect_q.delete();
    for (int i = 0; i < 6; i++) begin
        random_byte(b);
        if (i == 0) begin
            b[7] = 1'b0;                // Start bit of the response
        end
        expect_q.push_back(b);
    end
    load_miso(3);
    start_xfer(16'd6, 1'b0, 1'b1);
    wait_idle();
    read_rx_bytes(0, 6);
    reg_read(`SDSPI_REG_RXDATA, r);
    check_flag("RXDATA empty flag", r.rdata[31], 1'b1);
    if (mosi_low_seen) begin
        fail_with("MOSI went low during a receive transfer");
    end
endtask

task automatic receive_past_fifo_depth();
    reg_resp_t  r;
    logic [7:0] b;
    int         polls;
    int         fill_falls;
    int         held_falls;
    card_reset();
    expect_q.delete();
    for (int i = 0; i < max_bytes; i++) begin
        random_byte(b);
        if (i == 0) begin
            b[7] = 1'b0;
        end
        expect_q.push_back(b);
    end
    load_miso(2);
    fill_falls = 2 + fifo_depth * 8 + 1;    // Fall after the last bit of byte 16
    start_xfer(16'(max_bytes), 1'b0, 1'b1);
    polls = 0;
    while (sclk_falls < fill_falls) begin
        @(negedge i_clk);
        polls++;
        if (polls > (fill_falls + 8) * 4 * sck_div) begin
            fail_with("receive FIFO never filled during a long receive");
        end
    end
    held_falls = sclk_falls;
    repeat (16 * sck_div) @(negedge i_clk);     // One byte time with no room
    check_count("SPI clock falls while stalled", sclk_falls, held_falls);
    reg_read(`SDSPI_REG_CTRL, r);
    check_flag("CTRL busy while stalled", r.rdata[3], 1'b1);
    check_state("state while stalled", spi_state_e'(r.rdata[6:4]), st_wait_edge);
    read_rx_bytes(0, fifo_depth);
    wait_idle();
    read_rx_bytes(fifo_depth, max_bytes);
    reg_read(`SDSPI_REG_RXDATA, r);
    check_flag("RXDATA empty flag after drain", r.rdata[31], 1'b1);
    if (mosi_low_seen) begin
        fail_with("MOSI went low during a long receive transfer");
    end
endtask

//--- test/tb_sdspi.sv
`timescale 1ns/10ps

`include "sdspi_settings.svh"

module tb_sdspi import sdspi_pkg::*; ();

localparam int     n_tests        = 6;
localparam int     max_bytes      = 20;     // Longest transfer in any test
localparam int     sck_div        = 2;
localparam int     fifo_depth     = 1 << `SDSPI_FIFO_LOG2;
localparam int     bus_wait_limit = 64;
localparam longint timeout_ns     = n_tests * max_bytes * 16 * sck_div * 40 * 4;

logic      i_clk;
logic      i_nrst;
reg_req_t  i_req;
logic      i_req_valid;
logic      o_req_ready;
reg_resp_t o_resp;
logic      o_resp_valid;
logic      i_resp_ready;
logic      o_sclk;
logic      o_cs_n;
logic      o_mosi;
logic      i_miso;

logic [7:0] card_bytes[$];      // Bytes the card saw on MOSI
logic       miso_bits[$];       // Bits the card still has to send
logic [7:0] mosi_shift;
int         mosi_count;
int         sclk_falls;
logic       mosi_low_seen;
logic [31:0] lfsr_state;
logic [7:0]  expect_q[$];       // Expected bytes of the running test

sdspi_top DUT (
    .i_clk        (i_clk),
    .i_nrst       (i_nrst),
    .i_req        (i_req),
    .i_req_valid  (i_req_valid),
    .o_req_ready  (o_req_ready),
    .o_resp       (o_resp),
    .o_resp_valid (o_resp_valid),
    .i_resp_ready (i_resp_ready),
    .o_sclk       (o_sclk),
    .o_cs_n       (o_cs_n),
    .o_mosi       (o_mosi),
    .i_miso       (i_miso)
);

`include "tb_sdspi_tasks.svh"

initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
end

// Card model, MOSI captured on the rising SPI clock
always @(posedge o_sclk) begin
    if (!o_cs_n) begin
        if (!o_mosi) begin
            mosi_low_seen = 1'b1;
        end
        mosi_shift = {mosi_shift[6:0], o_mosi};
        mosi_count = mosi_count + 1;
        if (mosi_count == 8) begin
            card_bytes.push_back(mosi_shift);
            mosi_count = 0;
        end
    end
end

// Card model, next MISO bit on the falling SPI clock
always @(negedge o_sclk) begin
    sclk_falls = sclk_falls + 1;
    if (miso_bits.size() > 0) begin
        i_miso <= miso_bits.pop_front();
    end else begin
        i_miso <= 1'b1;                 // Card idles high
    end
end

// Watchdog
initial begin
    #(timeout_ns);
    $display("Watchdog expired at %0t: the tests did not finish in time", $time);
    abort_run();
end

initial begin
    i_nrst        = 1'b0;
    i_req         = '0;
    i_req_valid   = 1'b0;
    i_resp_ready  = 1'b1;
    i_miso        = 1'b1;
    lfsr_state    = 32'h651a;
    mosi_shift    = '0;
    mosi_count    = 0;
    sclk_falls    = 0;
    mosi_low_seen = 1'b0;
    repeat (5) @(posedge i_clk);
    i_nrst <= 1'b1;

    reset_and_register_access();
    transmit_fifo_bytes();
    transmit_cmd0_with_crc();
    transmit_underrun_and_full();
    receive_short_response();
    receive_past_fifo_depth();

    $display("TESTS PASSED");
    $finish;
end

endmodule

//--- list.f
+incdir+hw
+incdir+test
hw/sdspi_pkg.sv
hw/byte_fifo.sv
hw/sdspi_regs.sv
hw/sdspi_engine.sv
hw/sdspi_top.sv
test/tb_sdspi.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sdspi \
    -f list.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"
exit 0
